// File: hdl/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// Data and address width
`define MIPS_XLEN 32

// Architectural register count, register 0 is hardwired to zero
`define MIPS_NREGS 32

// First fetch address out of reset
`define MIPS_RESET_PC 32'h0000_0000

`endif

// File: hdl/mips_isa_pkg.sv
`include "mips_params.svh"

package mips_isa_pkg;

  typedef logic [`MIPS_XLEN-1:0] word_t;
  typedef logic [$clog2(`MIPS_NREGS)-1:0] reg_idx_t;

  // JAL link target
  localparam reg_idx_t LINK_REG = reg_idx_t'(`MIPS_NREGS - 1);

  typedef enum logic [5:0] {
    OP_RTYPE = 6'b000000,
    OP_J     = 6'b000010,
    OP_JAL   = 6'b000011,
    OP_BEQ   = 6'b000100,
    OP_ADDI  = 6'b001000,
    OP_SLTI  = 6'b001010,
    OP_ANDI  = 6'b001100,
    OP_ORI   = 6'b001101,
    OP_XORI  = 6'b001110,
    OP_LW    = 6'b100011,
    OP_SW    = 6'b101011
  } opcode_e;

  typedef enum logic [5:0] {
    FUNCT_JR  = 6'b001000,
    FUNCT_ADD = 6'b100000,
    FUNCT_SUB = 6'b100010,
    FUNCT_AND = 6'b100100,
    FUNCT_OR  = 6'b100101,
    FUNCT_XOR = 6'b100110,
    FUNCT_SLT = 6'b101010
  } funct_e;

  // Class from the main decoder, FUNC is refined by the ALU
  typedef enum logic [1:0] {
    ALU_OP_ADD  = 2'b00,
    ALU_OP_FUNC = 2'b10
  } alu_op_e;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_fn_e;

  typedef enum logic [1:0] {
    PC_SEQ    = 2'b00,
    PC_BRANCH = 2'b01,
    PC_JUMP   = 2'b10,
    PC_REG    = 2'b11
  } pc_src_e;

endpackage

// File: hdl/mips_pipe_pkg.sv
`include "mips_params.svh"

package mips_pipe_pkg;
  import mips_isa_pkg::*;

  // dst_reg_sel: 00 rt, 01 rd, 10 link register
  typedef struct packed {
    logic       alu_src_b;
    logic       alu_rslt_src;
    logic [1:0] dst_reg_sel;
    alu_op_e    alu_op;
    logic       imm_command;
  } ex_ctrl_t;

  typedef struct packed {
    logic read;
    logic write;
  } mem_ctrl_t;

  typedef struct packed {
    logic mem_to_reg;
    logic reg_write;
  } wb_ctrl_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    opcode_e   opcode;
    funct_e    funct;
    reg_idx_t  rs;
    reg_idx_t  rt;
    reg_idx_t  rd;
    word_t     rs_val;
    word_t     rt_val;
    word_t     imm;
    ex_ctrl_t  ex_ctrl;
    mem_ctrl_t mem_ctrl;
    wb_ctrl_t  wb_ctrl;
  } id_ex_t;

  typedef struct packed {
    logic      valid;
    word_t     pc;
    word_t     result;
    word_t     store_data;
    reg_idx_t  dst;
    mem_ctrl_t mem_ctrl;
    wb_ctrl_t  wb_ctrl;
  } ex_mem_t;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    word_t    result;
    word_t    rdata;
    reg_idx_t dst;
    wb_ctrl_t wb_ctrl;
  } mem_wb_t;

  typedef struct packed {
    logic                    cyc;
    logic                    stb;
    logic                    we;
    word_t                   adr;
    word_t                   dat;
    logic [`MIPS_XLEN/8-1:0] sel;
  } wb_req_t;

  typedef struct packed {
    logic  ack;
    word_t dat;
  } wb_rsp_t;

  typedef struct packed {
    logic     valid;
    word_t    pc;
    reg_idx_t rd;
    word_t    data;
  } retire_t;

  // Destination of the instruction sitting in ID/EX
  function automatic reg_idx_t dst_of(id_ex_t r);
    case (r.ex_ctrl.dst_reg_sel)
      2'b01:   return r.rd;
      2'b10:   return LINK_REG;
      default: return r.rt;
    endcase
  endfunction

endpackage

// File: hdl/control.sv
`timescale 1ns/1ps

module control
  import mips_isa_pkg::*;
  import mips_pipe_pkg::*;
(
  input  opcode_e   opcode,
  input  funct_e    special,
  input  logic      branch_eq,
  output pc_src_e   pc_source,
  output logic      rt_is_source,
  output ex_ctrl_t  ex_ctrl,
  output mem_ctrl_t mem_ctrl,
  output wb_ctrl_t  wb_ctrl
);

  logic memory_op;
  logic r_type_op;
  logic immediate_op;
  logic branch_op;
  logic jump_op;

  assign memory_op    = (opcode == OP_LW) || (opcode == OP_SW);
  assign r_type_op    = (opcode == OP_RTYPE);
  assign branch_op    = (opcode == OP_BEQ);
  assign jump_op      = (opcode == OP_J) || (opcode == OP_JAL);
  assign immediate_op = (opcode == OP_ADDI) || (opcode == OP_ANDI) || (opcode == OP_ORI) ||
                        (opcode == OP_XORI) || (opcode == OP_SLTI);

  // rt is read for R-type, BEQ compare and store data
  assign rt_is_source = r_type_op || branch_op || (opcode == OP_SW);

  always_comb begin
    pc_source            = PC_SEQ;
    ex_ctrl.alu_src_b    = 1'b0;
    ex_ctrl.alu_rslt_src = 1'b0;
    ex_ctrl.dst_reg_sel  = 2'b00;
    ex_ctrl.alu_op       = ALU_OP_ADD;
    ex_ctrl.imm_command  = immediate_op;
    mem_ctrl.read        = 1'b0;
    mem_ctrl.write       = 1'b0;
    wb_ctrl.mem_to_reg   = 1'b0;
    wb_ctrl.reg_write    = 1'b0;

    if (memory_op) begin
      ex_ctrl.alu_src_b = 1'b1;
      if (opcode == OP_LW) begin
        mem_ctrl.read      = 1'b1;
        wb_ctrl.mem_to_reg = 1'b1;
        wb_ctrl.reg_write  = 1'b1;
      end else begin
        mem_ctrl.write = 1'b1;
      end
    end else if (r_type_op) begin
      if (special == FUNCT_JR) begin
        pc_source = PC_REG;
      end else begin
        ex_ctrl.dst_reg_sel = 2'b01;
        ex_ctrl.alu_op      = ALU_OP_FUNC;
        wb_ctrl.reg_write   = 1'b1;
      end
    end else if (immediate_op) begin
      ex_ctrl.alu_src_b = 1'b1;
      ex_ctrl.alu_op    = ALU_OP_FUNC;
      wb_ctrl.reg_write = 1'b1;
    end else if (branch_op) begin
      if (branch_eq) begin
        pc_source = PC_BRANCH;
      end
    end else if (jump_op) begin
      pc_source = PC_JUMP;
      // JAL result is the link address, not the ALU output
      if (opcode == OP_JAL) begin
        ex_ctrl.dst_reg_sel  = 2'b10;
        ex_ctrl.alu_rslt_src = 1'b1;
        wb_ctrl.reg_write    = 1'b1;
      end
    end
  end

endmodule

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu
  import mips_isa_pkg::*;
(
  input  alu_op_e alu_op,
  input  logic    imm_command,
  input  opcode_e opcode,
  input  funct_e  funct,
  input  word_t   a,
  input  word_t   b,
  output word_t   result
);

  alu_fn_e fn;

  // Second-level decode
  always_comb begin
    fn = ALU_ADD;
    if (alu_op == ALU_OP_FUNC) begin
      if (imm_command) begin
        case (opcode)
          OP_ANDI: fn = ALU_AND;
          OP_ORI:  fn = ALU_OR;
          OP_XORI: fn = ALU_XOR;
          OP_SLTI: fn = ALU_SLT;
          default: fn = ALU_ADD;
        endcase
      end else begin
        case (funct)
          FUNCT_SUB: fn = ALU_SUB;
          FUNCT_AND: fn = ALU_AND;
          FUNCT_OR:  fn = ALU_OR;
          FUNCT_XOR: fn = ALU_XOR;
          FUNCT_SLT: fn = ALU_SLT;
          default:   fn = ALU_ADD;
        endcase
      end
    end
  end

  always_comb begin
    case (fn)
      ALU_SUB: result = a - b;
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_XOR: result = a ^ b;
      ALU_SLT: result = word_t'($signed(a) < $signed(b));
      default: result = a + b;
    endcase
  end

endmodule

// File: hdl/register_file.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module register_file
  import mips_isa_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  reg_idx_t rs_addr,
  input  reg_idx_t rt_addr,
  output word_t    rs_data,
  output word_t    rt_data,
  input  logic     wr_en,
  input  reg_idx_t wr_addr,
  input  word_t    wr_data
);

  word_t regs [1:`MIPS_NREGS-1];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < `MIPS_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && (wr_addr != '0)) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Write-through so decode sees the value retiring this cycle
  function automatic word_t read_port(reg_idx_t addr);
    if (addr == '0) return '0;
    if (wr_en && (wr_addr == addr)) return wr_data;
    return regs[addr];
  endfunction

  assign rs_data = read_port(rs_addr);
  assign rt_data = read_port(rt_addr);

endmodule

// File: hdl/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit
  import mips_isa_pkg::*;
  import mips_pipe_pkg::*;
(
  input  reg_idx_t   id_rs,
  input  reg_idx_t   id_rt,
  input  logic       id_rt_used,
  input  logic       id_uses_regs_early,
  input  id_ex_t     id_ex,
  input  ex_mem_t    ex_mem,
  input  mem_wb_t    mem_wb,
  input  logic       mem_busy,
  output logic [1:0] fwd_ex_a,
  output logic [1:0] fwd_ex_b,
  output logic       fwd_id_a,
  output logic       fwd_id_b,
  output logic       stall_if_id,
  output logic       bubble_ex,
  output logic       freeze
);

  reg_idx_t ex_dst;
  logic     ex_writes;
  logic     mem_writes;
  logic     wb_writes;
  logic     ex_hit;
  logic     mem_load_hit;
  logic     hazard;

  assign ex_dst     = dst_of(id_ex);
  assign ex_writes  = id_ex.valid && id_ex.wb_ctrl.reg_write && (ex_dst != '0);
  assign mem_writes = ex_mem.valid && ex_mem.wb_ctrl.reg_write && (ex_mem.dst != '0);
  assign wb_writes  = mem_wb.valid && mem_wb.wb_ctrl.reg_write && (mem_wb.dst != '0);

  // EX operands, newest producer first: 10 from MEM, 01 from WB
  always_comb begin
    fwd_ex_a = 2'b00;
    fwd_ex_b = 2'b00;
    if (mem_writes && (ex_mem.dst == id_ex.rs)) fwd_ex_a = 2'b10;
    else if (wb_writes && (mem_wb.dst == id_ex.rs)) fwd_ex_a = 2'b01;
    if (mem_writes && (ex_mem.dst == id_ex.rt)) fwd_ex_b = 2'b10;
    else if (wb_writes && (mem_wb.dst == id_ex.rt)) fwd_ex_b = 2'b01;
  end

  // Decode compare: WB arrives via register write-through, load data is not ready
  assign fwd_id_a = mem_writes && !ex_mem.mem_ctrl.read && (ex_mem.dst == id_rs);
  assign fwd_id_b = mem_writes && !ex_mem.mem_ctrl.read && (ex_mem.dst == id_rt);

  assign ex_hit       = ex_writes && ((ex_dst == id_rs) || (id_rt_used && (ex_dst == id_rt)));
  assign mem_load_hit = mem_writes && ex_mem.mem_ctrl.read &&
                        ((ex_mem.dst == id_rs) || (id_rt_used && (ex_mem.dst == id_rt)));

  // Load-use in EX, or an early consumer whose operand is not yet available
  assign hazard = (ex_hit && (id_ex.mem_ctrl.read || id_uses_regs_early)) ||
                  (mem_load_hit && id_uses_regs_early);

  assign stall_if_id = hazard;
  assign bubble_ex   = hazard;
  assign freeze      = mem_busy;

endmodule

// File: hdl/mips_core.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_core
  import mips_isa_pkg::*;
  import mips_pipe_pkg::*;
(
  input  logic    clk,
  input  logic    reset,
  output word_t   imem_addr,
  input  word_t   imem_data,
  output wb_req_t dwb_req,
  input  wb_rsp_t dwb_rsp,
  output retire_t retire
);

  word_t      pc;
  word_t      next_pc;
  logic       if_id_valid;
  word_t      if_id_pc;
  word_t      if_id_instr;
  id_ex_t     id_ex;
  id_ex_t     id_ex_next;
  ex_mem_t    ex_mem;
  mem_wb_t    mem_wb;

  opcode_e    id_opcode;
  funct_e     id_funct;
  reg_idx_t   id_rs;
  reg_idx_t   id_rt;
  word_t      id_imm;
  word_t      id_seq_pc;
  word_t      rf_rs_data;
  word_t      rf_rt_data;
  word_t      id_rs_val;
  word_t      id_rt_val;
  logic       branch_eq;
  logic       id_uses_regs_early;
  pc_src_e    ctrl_pc_source;
  logic       rt_is_source;
  ex_ctrl_t   ex_ctrl;
  mem_ctrl_t  mem_ctrl;
  wb_ctrl_t   wb_ctrl;

  logic [1:0] fwd_ex_a;
  logic [1:0] fwd_ex_b;
  logic       fwd_id_a;
  logic       fwd_id_b;
  logic       stall_if_id;
  logic       bubble_ex;
  logic       freeze;
  logic       mem_busy;
  logic       wb_gap;

  word_t      ex_a;
  word_t      ex_rt_val;
  word_t      ex_b;
  word_t      alu_result;
  word_t      wb_value;
  logic       wb_fire;

  // Fetch
  assign imem_addr = pc;

  always_ff @(posedge clk) begin
    if (reset) begin
      pc          <= `MIPS_RESET_PC;
      if_id_valid <= 1'b0;
    end else if (!freeze && !stall_if_id) begin
      pc          <= next_pc;
      if_id_valid <= 1'b1;
      if_id_pc    <= pc;
      if_id_instr <= imem_data;
    end
  end

  // Decode, with branches and jumps resolved here
  assign id_opcode = opcode_e'(if_id_instr[31:26]);
  assign id_funct  = funct_e'(if_id_instr[5:0]);
  assign id_rs     = if_id_instr[25:21];
  assign id_rt     = if_id_instr[20:16];
  assign id_seq_pc = if_id_pc + 32'd4;

  always_comb begin
    if (id_opcode inside {OP_ANDI, OP_ORI, OP_XORI}) begin
      id_imm = {16'h0000, if_id_instr[15:0]};
    end else begin
      id_imm = {{16{if_id_instr[15]}}, if_id_instr[15:0]};
    end
  end

  register_file u_register_file (
    .clk     (clk),
    .reset   (reset),
    .rs_addr (id_rs),
    .rt_addr (id_rt),
    .rs_data (rf_rs_data),
    .rt_data (rf_rt_data),
    .wr_en   (wb_fire),
    .wr_addr (mem_wb.dst),
    .wr_data (wb_value)
  );

  assign id_rs_val = fwd_id_a ? ex_mem.result : rf_rs_data;
  assign id_rt_val = fwd_id_b ? ex_mem.result : rf_rt_data;
  assign branch_eq = (id_rs_val == id_rt_val);

  assign id_uses_regs_early = if_id_valid &&
    ((id_opcode == OP_BEQ) || ((id_opcode == OP_RTYPE) && (id_funct == FUNCT_JR)));

  control u_control (
    .opcode       (id_opcode),
    .special      (id_funct),
    .branch_eq    (branch_eq),
    .pc_source    (ctrl_pc_source),
    .rt_is_source (rt_is_source),
    .ex_ctrl      (ex_ctrl),
    .mem_ctrl     (mem_ctrl),
    .wb_ctrl      (wb_ctrl)
  );

  always_comb begin
    next_pc = pc + 32'd4;
    if (if_id_valid) begin
      case (ctrl_pc_source)
        PC_BRANCH: next_pc = id_seq_pc + {id_imm[29:0], 2'b00};
        PC_JUMP:   next_pc = {id_seq_pc[31:28], if_id_instr[25:0], 2'b00};
        PC_REG:    next_pc = id_rs_val;
        default:   next_pc = pc + 32'd4;
      endcase
    end
  end

  always_comb begin
    id_ex_next.valid    = if_id_valid;
    id_ex_next.pc       = if_id_pc;
    id_ex_next.opcode   = id_opcode;
    id_ex_next.funct    = id_funct;
    id_ex_next.rs       = id_rs;
    id_ex_next.rt       = id_rt;
    id_ex_next.rd       = if_id_instr[15:11];
    id_ex_next.rs_val   = id_rs_val;
    id_ex_next.rt_val   = id_rt_val;
    id_ex_next.imm      = id_imm;
    id_ex_next.ex_ctrl  = ex_ctrl;
    id_ex_next.mem_ctrl = mem_ctrl;
    id_ex_next.wb_ctrl  = wb_ctrl;
  end

  hazard_unit u_hazard_unit (
    .id_rs              (id_rs),
    .id_rt              (id_rt),
    .id_rt_used         (rt_is_source),
    .id_uses_regs_early (id_uses_regs_early),
    .id_ex              (id_ex),
    .ex_mem             (ex_mem),
    .mem_wb             (mem_wb),
    .mem_busy           (mem_busy),
    .fwd_ex_a           (fwd_ex_a),
    .fwd_ex_b           (fwd_ex_b),
    .fwd_id_a           (fwd_id_a),
    .fwd_id_b           (fwd_id_b),
    .stall_if_id        (stall_if_id),
    .bubble_ex          (bubble_ex),
    .freeze             (freeze)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      id_ex.valid <= 1'b0;
    end else if (!freeze) begin
      id_ex       <= id_ex_next;
      id_ex.valid <= id_ex_next.valid && !bubble_ex;
    end
  end

  // Execute
  always_comb begin
    case (fwd_ex_a)
      2'b10:   ex_a = ex_mem.result;
      2'b01:   ex_a = wb_value;
      default: ex_a = id_ex.rs_val;
    endcase
    case (fwd_ex_b)
      2'b10:   ex_rt_val = ex_mem.result;
      2'b01:   ex_rt_val = wb_value;
      default: ex_rt_val = id_ex.rt_val;
    endcase
  end

  assign ex_b = id_ex.ex_ctrl.alu_src_b ? id_ex.imm : ex_rt_val;

  alu u_alu (
    .alu_op      (id_ex.ex_ctrl.alu_op),
    .imm_command (id_ex.ex_ctrl.imm_command),
    .opcode      (id_ex.opcode),
    .funct       (id_ex.funct),
    .a           (ex_a),
    .b           (ex_b),
    .result      (alu_result)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_mem.valid <= 1'b0;
    end else if (!freeze) begin
      ex_mem.valid      <= id_ex.valid;
      ex_mem.pc         <= id_ex.pc;
      ex_mem.result     <= id_ex.ex_ctrl.alu_rslt_src ? id_ex.pc + 32'd8 : alu_result;
      ex_mem.store_data <= ex_rt_val;
      ex_mem.dst        <= dst_of(id_ex);
      ex_mem.mem_ctrl   <= id_ex.mem_ctrl;
      ex_mem.wb_ctrl    <= id_ex.wb_ctrl;
    end
  end

  // Memory access over Wishbone, idle for one cycle after each ack
  always_comb begin
    dwb_req.cyc = ex_mem.valid && (ex_mem.mem_ctrl.read || ex_mem.mem_ctrl.write) && !wb_gap;
    dwb_req.stb = dwb_req.cyc;
    dwb_req.we  = ex_mem.mem_ctrl.write;
    dwb_req.adr = ex_mem.result;
    dwb_req.dat = ex_mem.store_data;
    dwb_req.sel = '1;
  end

  assign mem_busy = ex_mem.valid && (ex_mem.mem_ctrl.read || ex_mem.mem_ctrl.write) &&
                    !(dwb_req.stb && dwb_rsp.ack);

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_gap <= 1'b0;
    end else begin
      wb_gap <= dwb_req.stb && dwb_rsp.ack;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mem_wb.valid <= 1'b0;
    end else if (!freeze) begin
      mem_wb.valid   <= ex_mem.valid;
      mem_wb.pc      <= ex_mem.pc;
      mem_wb.result  <= ex_mem.result;
      mem_wb.rdata   <= dwb_rsp.dat;
      mem_wb.dst     <= ex_mem.dst;
      mem_wb.wb_ctrl <= ex_mem.wb_ctrl;
    end
  end

  // Writeback and retire, held back while the pipeline is frozen
  assign wb_value = mem_wb.wb_ctrl.mem_to_reg ? mem_wb.rdata : mem_wb.result;
  assign wb_fire  = mem_wb.valid && mem_wb.wb_ctrl.reg_write && !freeze;

  always_comb begin
    retire.valid = wb_fire && (mem_wb.dst != '0);
    retire.pc    = mem_wb.pc;
    retire.rd    = mem_wb.dst;
    retire.data  = wb_value;
  end

endmodule

// File: dv/mips_checker.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_checker
  import mips_isa_pkg::*;
  import mips_pipe_pkg::*;
(
  input logic    clk,
  input logic    reset,
  input word_t   imem_addr,
  input wb_req_t dwb_req,
  input wb_rsp_t dwb_rsp,
  input retire_t retire
);

  word_t   prog [0:255];
  word_t   data [0:63];
  retire_t exp_writes [$];
  wb_req_t exp_access [$];
  int      expected_retires = 0;
  int      retired = 0;
  int      value_errors = 0;
  int      protocol_errors = 0;
  retire_t want_write;
  wb_req_t want_access;
  wb_req_t prev_req;
  logic    prev_waiting = 1'b0;
  logic    prev_acked = 1'b0;

  task automatic put_instruction(input int idx, input word_t word);
    prog[idx] = word;
  endtask

  task automatic preload_memory(input int idx, input word_t word);
    data[idx] = word;
  endtask

  task automatic report_value(input string name, input word_t expected, input word_t actual);
    value_errors++;
    $display("ERROR %s: expected %h, actual %h", name, expected, actual);
  endtask

  // ISA model with one delay slot, run once to the final self-loop
  task automatic run_model(input word_t stop_pc);
    word_t    regs [0:31];
    word_t    pc;
    word_t    npc;
    word_t    target;
    word_t    instr;
    word_t    a;
    word_t    b;
    word_t    imm_s;
    word_t    imm_z;
    word_t    value;
    logic     writes;
    reg_idx_t dst;
    retire_t  rec;
    wb_req_t  acc;
    int       steps;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    pc    = `MIPS_RESET_PC;
    npc   = pc + 32'd4;
    steps = 0;
    while (pc != stop_pc && steps < 10000) begin
      instr  = prog[pc[9:2]];
      a      = regs[instr[25:21]];
      b      = regs[instr[20:16]];
      imm_s  = {{16{instr[15]}}, instr[15:0]};
      imm_z  = {16'h0000, instr[15:0]};
      target = npc + 32'd4;
      writes = 1'b1;
      dst    = instr[20:16];
      value  = '0;
      acc    = '0;
      acc.cyc = 1'b1;
      acc.stb = 1'b1;
      acc.sel = '1;
      acc.adr = a + imm_s;
      case (instr[31:26])
        OP_RTYPE: begin
          dst = instr[15:11];
          case (instr[5:0])
            FUNCT_ADD: value = a + b;
            FUNCT_SUB: value = a - b;
            FUNCT_AND: value = a & b;
            FUNCT_OR:  value = a | b;
            FUNCT_XOR: value = a ^ b;
            FUNCT_SLT: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            FUNCT_JR: begin
              writes = 1'b0;
              target = a;
            end
            default:   writes = 1'b0;
          endcase
        end
        OP_ADDI: value = a + imm_s;
        OP_SLTI: value = ($signed(a) < $signed(imm_s)) ? 32'd1 : 32'd0;
        OP_ANDI: value = a & imm_z;
        OP_ORI:  value = a | imm_z;
        OP_XORI: value = a ^ imm_z;
        OP_LW: begin
          value = data[acc.adr[7:2]];
          exp_access.push_back(acc);
        end
        OP_SW: begin
          writes  = 1'b0;
          acc.we  = 1'b1;
          acc.dat = b;
          data[acc.adr[7:2]] = b;
          exp_access.push_back(acc);
        end
        OP_BEQ: begin
          writes = 1'b0;
          if (a == b) begin
            target = pc + 32'd4 + {imm_s[29:0], 2'b00};
          end
        end
        OP_J: begin
          writes = 1'b0;
          target = {pc[31:28], instr[25:0], 2'b00};
        end
        OP_JAL: begin
          dst    = LINK_REG;
          value  = pc + 32'd8;
          target = {pc[31:28], instr[25:0], 2'b00};
        end
        default: writes = 1'b0;
      endcase
      if (writes && dst != '0) begin
        regs[dst]  = value;
        rec.valid  = 1'b1;
        rec.pc     = pc;
        rec.rd     = dst;
        rec.data   = value;
        exp_writes.push_back(rec);
      end
      pc    = npc;
      npc   = target;
      steps = steps + 1;
    end
    if (pc != stop_pc) begin
      protocol_errors++;
      $display("Reference model never reached the final loop at %h", stop_pc);
    end
    expected_retires = exp_writes.size();
  endtask

  task automatic flag_missing_events();
    if (exp_writes.size() != 0) begin
      protocol_errors++;
      $display("%0d expected register writes never retired", exp_writes.size());
    end
    if (exp_access.size() != 0) begin
      protocol_errors++;
      $display("%0d expected data accesses never appeared on the bus", exp_access.size());
    end
  endtask

  // Sampled mid-cycle, after the testbench has driven its inputs
  always @(negedge clk) begin
    if (reset) begin
      if (retire.valid !== 1'b0 || dwb_req.cyc !== 1'b0 || dwb_req.stb !== 1'b0) begin
        protocol_errors++;
        $display("Retire or Wishbone request active while reset is asserted");
      end
      if (imem_addr !== `MIPS_RESET_PC) begin
        report_value("reset_pc", `MIPS_RESET_PC, imem_addr);
      end
      prev_waiting = 1'b0;
      prev_acked   = 1'b0;
    end else begin
      if (retire.valid === 1'b1) begin
        retired++;
        if (exp_writes.size() == 0) begin
          protocol_errors++;
          $display("Retire of r%0d at pc %h beyond the model's last write", retire.rd, retire.pc);
        end else begin
          want_write = exp_writes.pop_front();
          if (retire.pc !== want_write.pc) begin
            report_value("retire_pc", want_write.pc, retire.pc);
          end
          if (retire.rd !== want_write.rd) begin
            report_value("retire_rd", word_t'(want_write.rd), word_t'(retire.rd));
          end
          if (retire.data !== want_write.data) begin
            report_value("retire_data", want_write.data, retire.data);
          end
        end
      end

      // Request must hold until acknowledged
      if (prev_waiting) begin
        if (dwb_req.cyc !== 1'b1 || dwb_req.stb !== 1'b1) begin
          protocol_errors++;
          $display("Wishbone cyc or stb dropped before ack at address %h", prev_req.adr);
        end else begin
          if (dwb_req.we !== prev_req.we) begin
            report_value("bus_hold_we", word_t'(prev_req.we), word_t'(dwb_req.we));
          end
          if (dwb_req.adr !== prev_req.adr) begin
            report_value("bus_hold_adr", prev_req.adr, dwb_req.adr);
          end
          if (dwb_req.dat !== prev_req.dat) begin
            report_value("bus_hold_dat", prev_req.dat, dwb_req.dat);
          end
        end
      end

      // Cycle ends in the cycle after ack
      if (prev_acked && (dwb_req.cyc !== 1'b0 || dwb_req.stb !== 1'b0)) begin
        protocol_errors++;
        $display("Wishbone cyc or stb still high in the cycle after ack");
      end

      if (dwb_req.stb === 1'b1 && dwb_rsp.ack !== 1'b1 && retire.valid === 1'b1) begin
        protocol_errors++;
        $display("Register write retired while a data access waits for ack");
      end

      if (dwb_req.cyc === 1'b1 && dwb_req.stb === 1'b1 && dwb_rsp.ack === 1'b1) begin
        if (exp_access.size() == 0) begin
          protocol_errors++;
          $display("Data access at %h that the model does not make", dwb_req.adr);
        end else begin
          want_access = exp_access.pop_front();
          if (dwb_req.we !== want_access.we) begin
            report_value("bus_we", word_t'(want_access.we), word_t'(dwb_req.we));
          end
          if (dwb_req.adr !== want_access.adr) begin
            report_value("bus_adr", want_access.adr, dwb_req.adr);
          end
          if (dwb_req.sel !== want_access.sel) begin
            report_value("bus_sel", word_t'(want_access.sel), word_t'(dwb_req.sel));
          end
          if (want_access.we && dwb_req.dat !== want_access.dat) begin
            report_value("bus_dat", want_access.dat, dwb_req.dat);
          end
        end
      end

      prev_waiting = (dwb_req.cyc === 1'b1) && (dwb_req.stb === 1'b1) && (dwb_rsp.ack !== 1'b1);
      prev_acked   = (dwb_req.cyc === 1'b1) && (dwb_req.stb === 1'b1) && (dwb_rsp.ack === 1'b1);
      prev_req     = dwb_req;
    end
  end

endmodule

// File: dv/mips_core_tb.sv
`timescale 1ns/1ps

module mips_core_tb
  import mips_isa_pkg::*;
  import mips_pipe_pkg::*;
();

  localparam int PROG_LEN   = 200;
  localparam int LOOP_IDX   = PROG_LEN - 2;
  localparam int DATA_WORDS = 64;
  localparam int TIMEOUT    = 5000;

  logic    clk = 1'b0;
  logic    reset;
  word_t   imem_addr;
  word_t   imem_data;
  wb_req_t dwb_req;
  wb_rsp_t dwb_rsp;
  retire_t retire;

  word_t rom [0:PROG_LEN-1];
  word_t dmem [0:DATA_WORDS-1];
  word_t rng;
  logic  pending;
  int    wait_left;
  logic  ack_now;
  word_t read_word;
  int    cycles;
  int    timeouts;

  mips_core dut_i (
    .clk       (clk),
    .reset     (reset),
    .imem_addr (imem_addr),
    .imem_data (imem_data),
    .dwb_req   (dwb_req),
    .dwb_rsp   (dwb_rsp),
    .retire    (retire)
  );

  mips_checker checker_i (
    .clk       (clk),
    .reset     (reset),
    .imem_addr (imem_addr),
    .dwb_req   (dwb_req),
    .dwb_rsp   (dwb_rsp),
    .retire    (retire)
  );

  function automatic word_t xorshift(input word_t x);
    word_t y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic word_t next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  function automatic word_t r_type_word(funct_e fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd);
    return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic word_t imm_word(opcode_e op, reg_idx_t rs, reg_idx_t rt, logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic word_t jump_word(opcode_e op, int target_idx);
    return {op, 26'(target_idx)};
  endfunction

  function automatic funct_e pick_funct(input logic [2:0] n);
    case (n)
      3'd0:    return FUNCT_SUB;
      3'd1:    return FUNCT_AND;
      3'd2:    return FUNCT_OR;
      3'd3:    return FUNCT_XOR;
      3'd4:    return FUNCT_SLT;
      default: return FUNCT_ADD;
    endcase
  endfunction

  function automatic opcode_e pick_logic_op(input logic [1:0] n);
    case (n)
      2'd0:    return OP_ANDI;
      2'd1:    return OP_ORI;
      default: return OP_XORI;
    endcase
  endfunction

  // Few registers so that neighbours depend on each other often
  function automatic word_t random_plain();
    word_t       r;
    reg_idx_t    rs;
    reg_idx_t    rt;
    reg_idx_t    rd;
    logic [15:0] offset;
    r      = next_rand();
    rs     = reg_idx_t'(r[10:8]);
    rt     = reg_idx_t'(r[13:11]);
    rd     = reg_idx_t'(r[16:14]);
    offset = {8'h00, r[29:24], 2'b00};
    case (r[2:0])
      3'd0, 3'd1: return r_type_word(pick_funct(r[20:18]), rs, rt, rd);
      3'd2:       return imm_word(OP_ADDI, rs, rt, r[31:16]);
      3'd3:       return imm_word(pick_logic_op(r[19:18]), rs, rt, r[31:16]);
      3'd4:       return imm_word(OP_SLTI, rs, rt, r[31:16]);
      3'd5, 3'd6: return imm_word(OP_LW, 5'd0, rt, offset);
      default:    return imm_word(OP_SW, 5'd0, rt, offset);
    endcase
  endfunction

  task automatic build_program();
    int    n;
    int    kind;
    int    skip;
    word_t r;
    n = 0;
    while (n < LOOP_IDX) begin
      kind = next_rand() % 16;
      if ((LOOP_IDX - n) < 9 || kind < 10) begin
        rom[n] = random_plain();
        n = n + 1;
      end else if (kind < 14) begin
        // Forward BEQ or J past its delay slot and up to two skipped words
        skip = next_rand() % 3;
        r    = next_rand();
        if (kind < 12) begin
          rom[n] = imm_word(OP_BEQ, reg_idx_t'(r[1:0]), reg_idx_t'(r[3:2]), 16'(skip + 1));
        end else begin
          rom[n] = jump_word(OP_J, n + 2 + skip);
        end
        for (int i = 1; i <= skip + 1; i++) begin
          rom[n + i] = random_plain();
        end
        n = n + 2 + skip;
      end else begin
        // JAL, slot, J over the body, slot, body, JR through the link register, slot
        skip = next_rand() % 3;
        rom[n]            = jump_word(OP_JAL, n + 4);
        rom[n + 2]        = jump_word(OP_J, n + 6 + skip);
        rom[n + 4 + skip] = r_type_word(FUNCT_JR, LINK_REG, 5'd0, 5'd0);
        for (int i = 1; i < 6 + skip; i++) begin
          if (i != 2 && i != 4 + skip) begin
            rom[n + i] = random_plain();
          end
        end
        n = n + 6 + skip;
      end
    end
    rom[LOOP_IDX]     = imm_word(OP_BEQ, 5'd0, 5'd0, 16'hFFFF);
    rom[LOOP_IDX + 1] = '0;
  endtask

  function automatic word_t fill_word(int idx);
    return (32'(idx * 4) * 32'h9E37_79B9) ^ 32'h5A5A_C3C3;
  endfunction

  initial begin
    forever #2 clk = ~clk;
  end

  // Instruction ROM, answers the address of the current cycle
  always @(posedge clk) begin
    #1;
    if (imem_addr[31:2] < PROG_LEN) begin
      imem_data = rom[imem_addr[31:2]];
    end else begin
      imem_data = '0;
    end
  end

  // Wishbone memory with 0 to 3 wait cycles per access
  always @(posedge clk) begin
    #1;
    ack_now   = 1'b0;
    read_word = '0;
    if (reset) begin
      pending = 1'b0;
    end else if (dwb_req.cyc && dwb_req.stb) begin
      if (!pending) begin
        pending   = 1'b1;
        wait_left = next_rand() % 4;
      end
      if (wait_left == 0) begin
        pending = 1'b0;
        ack_now = 1'b1;
        if (dwb_req.we) begin
          dmem[dwb_req.adr[7:2]] = dwb_req.dat;
        end else begin
          read_word = dmem[dwb_req.adr[7:2]];
        end
      end else begin
        wait_left = wait_left - 1;
      end
    end
    dwb_rsp.ack = ack_now;
    dwb_rsp.dat = read_word;
  end

  initial begin
    reset     = 1'b1;
    imem_data = '0;
    dwb_rsp   = '0;
    pending   = 1'b0;
    wait_left = 0;
    timeouts  = 0;
    rng       = 32'h1164_0987;
    build_program();
    for (int i = 0; i < PROG_LEN; i++) begin
      checker_i.put_instruction(i, rom[i]);
    end
    for (int i = 0; i < DATA_WORDS; i++) begin
      dmem[i] = fill_word(i);
      checker_i.preload_memory(i, dmem[i]);
    end
    checker_i.run_model(word_t'(LOOP_IDX * 4));

    repeat (4) @(posedge clk);
    #1 reset = 1'b0;

    cycles = 0;
    while (checker_i.retired < checker_i.expected_retires && cycles < TIMEOUT) begin
      @(posedge clk);
      cycles = cycles + 1;
    end
    if (checker_i.retired < checker_i.expected_retires) begin
      timeouts = timeouts + 1;
      $display("Timeout after %0d cycles, %0d of %0d register writes retired",
               cycles, checker_i.retired, checker_i.expected_retires);
    end else begin
      // Pipeline depth plus margin, catches writes past the last expected one
      repeat (8) @(posedge clk);
    end
    checker_i.flag_missing_events();

    $display("Errors: %0d value, %0d protocol, %0d timeout",
             checker_i.value_errors, checker_i.protocol_errors, timeouts);
    if (checker_i.value_errors + checker_i.protocol_errors + timeouts == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

// File: mips_core.f
+incdir+hdl
hdl/mips_isa_pkg.sv
hdl/mips_pipe_pkg.sv
hdl/control.sv
hdl/alu.sv
hdl/register_file.sv
hdl/hazard_unit.sv
hdl/mips_core.sv
dv/mips_checker.sv
dv/mips_core_tb.sv
